// File: common/opn_pkg.sv
package opn_pkg;

	// Phase accumulator width. The top bits of the phase would address
	// the sine table in a full operator, which is not part of this block.
	localparam int PHASE_W = 20;

	// Slot numbers cover up to 32 slots, enough for the 24 of the chip.
	localparam int SLOT_W = 5;

	typedef logic [PHASE_W-1:0] phase_t;

	typedef logic [SLOT_W-1:0] slot_idx_t;

	// Per-slot frequency setting.
	// The field order mirrors the APB data layout, with mult on top.
	typedef struct packed {
		logic [3:0] mult;
		logic [2:0] block;
		logic [10:0] fnum;
	} slot_cfg_t;

	// One record of the output stream, a slot number and its new phase.
	typedef struct packed {
		slot_idx_t slot;
		phase_t phase;
	} slot_rec_t;

	// Bit positions of the configuration fields in pwdata and prdata.
	localparam int FNUM_LSB = 0;
	localparam int FNUM_MSB = 10;
	localparam int BLOCK_LSB = 11;
	localparam int BLOCK_MSB = 13;
	localparam int MULT_LSB = 14;
	localparam int MULT_MSB = 17;

	// The slot number sits in paddr above the byte offset.
	localparam int ADDR_SLOT_LSB = 2;
	localparam int ADDR_SLOT_MSB = 6;

endpackage

// File: source/slot_ring.sv
`timescale 1ns/1ps

module slot_ring #(
	parameter int SLOTS = 24,
	parameter type payload_t = logic [7:0]
) (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input payload_t din,
	output payload_t tail
);

	// Stage 0 is the head, stage SLOTS-1 is the tail.
	// A record written at the head comes out at the tail SLOTS enables later,
	// so the tail always belongs to the slot the timer is pointing at.
	payload_t stage [SLOTS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < SLOTS; i++) begin
				stage[i] <= '0;
			end
		end else if (clk_en) begin
			// The whole ring moves one slot per enable and never between enables.
			stage[0] <= din;
			for (int i = 1; i < SLOTS; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign tail = stage[SLOTS-1];

	// The two rings only line up if neither moves off the enable.
	// A stray shift would pair one slot's phase with another slot's settings.
	a_tail_only_on_enable: assert property (
		@(posedge clk) disable iff (reset)
		!clk_en |=> $stable(tail)
	) else $error("slot ring tail moved without clk_en");

endmodule

// File: source/slot_timer.sv
`timescale 1ns/1ps

module slot_timer import opn_pkg::*; #(
	parameter int SLOTS = 24,
	parameter int PRESCALE = 4
) (
	input logic clk,
	input logic reset,
	output logic clk_en,
	output slot_idx_t slot
);

	// A width of one bit still works when PRESCALE is 1.
	localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

	logic [PW-1:0] pre_cnt;

	// The enable is the last count of the prescaler, one clk wide.
	assign clk_en = (pre_cnt == PW'(PRESCALE - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			pre_cnt <= '0;
			slot <= '0;
		end else if (clk_en) begin
			pre_cnt <= '0;
			// Slot numbers run 0 to SLOTS-1 and then start a new frame.
			if (slot == slot_idx_t'(SLOTS - 1)) begin
				slot <= '0;
			end else begin
				slot <= slot + 1'b1;
			end
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	a_slot_in_range: assert property (
		@(posedge clk) disable iff (reset)
		int'(slot) < SLOTS
	) else $error("slot counter left the range 0 to SLOTS-1");

endmodule

// File: regs/apb_slot_regs.sv
`timescale 1ns/1ps

module apb_slot_regs import opn_pkg::*; #(
	parameter int SLOTS = 24
) (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input slot_idx_t slot,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [6:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output slot_cfg_t cfg
);

	// The settings are not held in an addressable array.
	// They circulate in a ring, and a transfer waits until its slot is at the tail.
	slot_idx_t tgt;
	logic tgt_ok;
	logic access;
	logic slot_hit;
	logic wr_hit;
	slot_cfg_t wr_cfg;
	slot_cfg_t head;
	slot_cfg_t tail;

	// Word addresses, so the two low address bits play no part in the decode.
	assign tgt = paddr[ADDR_SLOT_MSB:ADDR_SLOT_LSB];
	assign tgt_ok = (int'(tgt) < SLOTS);

	// The access phase is the second and later cycles of a transfer.
	assign access = psel && penable;

	// The target slot is at the tail only on the enable that will shift it out.
	assign slot_hit = access && tgt_ok && clk_en && (slot == tgt);
	assign wr_hit = slot_hit && pwrite;

	// Unpack the write data into the configuration fields.
	always_comb begin
		wr_cfg.fnum = pwdata[FNUM_MSB:FNUM_LSB];
		wr_cfg.block = pwdata[BLOCK_MSB:BLOCK_LSB];
		wr_cfg.mult = pwdata[MULT_MSB:MULT_LSB];
	end

	// Normally the tail record goes back in at the head unchanged.
	// A matching write replaces it for this one pass.
	assign head = wr_hit ? wr_cfg : tail;

	slot_ring #(
		.SLOTS(SLOTS),
		.payload_t(slot_cfg_t)
	) cfg_ring_i (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.din(head),
		.tail(tail)
	);

	// A bad slot ends at once with an error.
	// A good slot waits for its turn at the tail, which can take a full frame.
	assign pready = access && (!tgt_ok || slot_hit);
	assign pslverr = access && !tgt_ok;

	// Read data is the tail record, laid out like the write data.
	always_comb begin
		prdata = '0;
		if (access && !pwrite && tgt_ok) begin
			prdata[FNUM_MSB:FNUM_LSB] = tail.fnum;
			prdata[BLOCK_MSB:BLOCK_LSB] = tail.block;
			prdata[MULT_MSB:MULT_LSB] = tail.mult;
		end
	end

	// The phase generator sees the settings before any write merge.
	// A new setting therefore takes effect on the slot's next pass.
	assign cfg = tail;

	// A completion must belong to a transfer that went through its setup cycle.
	a_pready_in_access: assert property (
		@(posedge clk) disable iff (reset)
		pready |-> (psel && penable && $past(psel))
	) else $error("pready outside an APB access phase");

endmodule

// File: phase/phase_step.sv
`timescale 1ns/1ps

module phase_step import opn_pkg::*; (
	input slot_cfg_t cfg,
	output phase_t step
);

	// The block is an octave shift on the frequency number.
	// fnum is 11 bits and block goes up to 7, so 18 bits hold every shift.
	logic [17:0] shifted;

	// One bit is dropped after the shift, leaving a 17-bit base.
	logic [16:0] base;

	logic [19:0] prod;

	assign shifted = 18'(cfg.fnum) << cfg.block;
	assign base = shifted[17:1];

	// Multiplier values 1 to 15 scale the base directly.
	// The top of a large product falls off at the phase width.
	assign prod = 20'(base) * 20'(cfg.mult);

	// A multiplier of zero stands for one half.
	assign step = (cfg.mult == 4'd0) ? phase_t'(base >> 1) : prod;

endmodule

// File: phase/phase_gen.sv
`timescale 1ns/1ps

module phase_gen import opn_pkg::*; #(
	parameter int SLOTS = 24
) (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input slot_idx_t slot,
	input slot_cfg_t cfg,
	output slot_rec_t rec
);

	// All slots share this one adder.
	// Each slot gets it on the enable where its phase is at the ring tail.
	phase_t ph_tail;
	phase_t ph_sum;
	phase_t step;

	phase_step phase_step_i (
		.cfg(cfg),
		.step(step)
	);

	// The sum wraps at 2^20, which is how the phase rolls over a full cycle.
	assign ph_sum = ph_tail + step;

	// The phase ring shifts on the same enables as the settings ring.
	// Its tail and cfg therefore always describe the same slot.
	slot_ring #(
		.SLOTS(SLOTS),
		.payload_t(phase_t)
	) phase_ring_i (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.din(ph_sum),
		.tail(ph_tail)
	);

	// The record carries the updated phase, the same value that enters the head.
	always_comb begin
		rec.slot = slot;
		rec.phase = ph_sum;
	end

endmodule

// File: source/slot_out.sv
`timescale 1ns/1ps

module slot_out import opn_pkg::*; #(
	parameter int SLOTS = 24
) (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input slot_rec_t rec,
	output slot_rec_t out_rec,
	output logic out_valid,
	output logic frame
);

	// Next slot number the stream should carry.
	slot_idx_t exp_slot;

	// The record is only meaningful while out_valid is high.
	always_ff @(posedge clk) begin
		if (clk_en) begin
			out_rec <= rec;
		end
	end

	// One strobe per enable, a clk after the enable that made the record.
	// The frame marker flags the last slot so a consumer can find slot 0.
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			frame <= 1'b0;
		end else begin
			out_valid <= clk_en;
			frame <= clk_en && (rec.slot == slot_idx_t'(SLOTS - 1));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			exp_slot <= '0;
		end else if (out_valid) begin
			exp_slot <= (out_rec.slot == slot_idx_t'(SLOTS - 1)) ? '0 : out_rec.slot + 1'b1;
		end
	end

	// The stream starts at slot 0 after reset and never skips or repeats a slot.
	// A gap here means the timer and the rings have fallen out of step.
	a_slot_order: assert property (
		@(posedge clk) disable iff (reset)
		out_valid |-> (out_rec.slot == exp_slot)
	) else $error("output slot %0d out of order, expected %0d", out_rec.slot, exp_slot);

endmodule

// File: source/opn_phase_top.sv
`timescale 1ns/1ps

module opn_phase_top import opn_pkg::*; #(
	parameter int SLOTS = 24,
	parameter int PRESCALE = 4
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [6:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output slot_rec_t out_rec,
	output logic out_valid,
	output logic frame
);

	logic clk_en;
	slot_idx_t slot;
	slot_cfg_t cfg;
	slot_rec_t rec;

	// The timer paces every block, one slot per enable.
	slot_timer #(
		.SLOTS(SLOTS),
		.PRESCALE(PRESCALE)
	) slot_timer_i (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.slot(slot)
	);

	apb_slot_regs #(
		.SLOTS(SLOTS)
	) apb_slot_regs_i (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.slot(slot),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cfg(cfg)
	);

	phase_gen #(
		.SLOTS(SLOTS)
	) phase_gen_i (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.slot(slot),
		.cfg(cfg),
		.rec(rec)
	);

	slot_out #(
		.SLOTS(SLOTS)
	) slot_out_i (
		.clk(clk),
		.reset(reset),
		.clk_en(clk_en),
		.rec(rec),
		.out_rec(out_rec),
		.out_valid(out_valid),
		.frame(frame)
	);

endmodule

// File: verif/opn_phase_tb.sv
`timescale 1ns/1ps

module opn_phase_tb
	import opn_pkg::*;
();

	localparam int SLOTS = 24;
	localparam int PRESCALE = 4;
	localparam int CLK_PERIOD = 100;
	localparam int FRAME_CYCLES = SLOTS * PRESCALE;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [6:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	slot_rec_t out_rec;
	logic out_valid;
	logic frame;

	// Latest phase and number of outputs seen for every slot.
	phase_t last_phase [SLOTS];
	int out_count [SLOTS];

	// The watchdog budget scales with the length of the stimulus file.
	int n_lines;
	logic lines_counted;

	opn_phase_top opn_phase_top_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.out_rec(out_rec),
		.out_valid(out_valid),
		.frame(frame)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED at time %0t: %s got 0x%0h expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	// Packs the three fields the way the APB data bus carries them.
	function automatic logic [31:0] cfg_word(input int fnum, input int blk, input int mul);
		logic [31:0] word;
		word = '0;
		word[FNUM_MSB:FNUM_LSB] = fnum[10:0];
		word[BLOCK_MSB:BLOCK_LSB] = blk[2:0];
		word[MULT_MSB:MULT_LSB] = mul[3:0];
		return word;
	endfunction

	// Returns at the first falling edge where out_valid is high.
	task automatic wait_valid();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!out_valid) begin
			cycles++;
			if (cycles > PRESCALE + 1) begin
				abort_run("no out_valid strobe arrived within one enable period");
			end
			@(negedge clk);
		end
	endtask

	// One APB transfer. pready is sampled a quarter period after the falling edge,
	// where it already reflects this cycle's inputs and holds until the rising edge.
	task automatic apb_transfer(input logic wr, input int slot, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err, output int waited);
		waited = 0;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = 7'(slot << 2);
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		while (!pready) begin
			waited++;
			if (waited > FRAME_CYCLES + 2) begin
				abort_run($sformatf("APB transfer to slot %0d is stuck without pready", slot));
			end
			@(negedge clk);
			#(CLK_PERIOD / 4);
		end
		rdata = prdata;
		err = pslverr;
		// The transfer ends on the rising edge, so the bus is released after it.
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic wait_slot_output(input slot_idx_t idx, input int target);
		int waited;
		waited = 0;
		while (out_count[idx] < target) begin
			@(negedge clk);
			waited++;
			if (waited > FRAME_CYCLES + PRESCALE + 2) begin
				abort_run($sformatf("slot %0d produced no output for a whole frame", idx));
			end
		end
	endtask

	// The difference of two consecutive phases of a slot is its step, mod 2^20.
	task automatic check_step(input slot_idx_t idx, input logic [31:0] step);
		int start;
		phase_t first;
		phase_t diff;
		start = out_count[idx];
		wait_slot_output(idx, start + 1);
		first = last_phase[idx];
		wait_slot_output(idx, start + 2);
		diff = last_phase[idx] - first;
		check_equal($sformatf("phase step of slot %0d", idx), 32'(diff), step);
	endtask

	// Right after reset every slot comes out in order with a zero phase.
	task automatic check_reset_stream();
		for (int f = 0; f < 2; f++) begin
			for (int s = 0; s < SLOTS; s++) begin
				wait_valid();
				check_equal("out_rec.slot", 32'(out_rec.slot), 32'(s));
				check_equal("frame", 32'(frame), 32'(s == SLOTS - 1));
				check_equal("out_rec.phase", 32'(out_rec.phase), 32'd0);
			end
		end
	endtask

	// Output monitor. frame must only ever come with the last slot.
	always @(negedge clk) begin
		if (reset) begin
			for (int i = 0; i < SLOTS; i++) begin
				last_phase[i] <= '0;
				out_count[i] <= 0;
			end
		end else if (out_valid) begin
			check_equal("out_rec.slot below SLOTS", 32'(int'(out_rec.slot) < SLOTS), 32'd1);
			check_equal("frame", 32'(frame), 32'(out_rec.slot == slot_idx_t'(SLOTS - 1)));
			last_phase[out_rec.slot] <= out_rec.phase;
			out_count[out_rec.slot] <= out_count[out_rec.slot] + 1;
		end else begin
			check_equal("frame", 32'(frame), 32'd0);
		end
	end

	initial begin
		wait (lines_counted);
		#((n_lines + 2) * 4 * FRAME_CYCLES * CLK_PERIOD);
		abort_run("watchdog timeout, the run took longer than the stimulus allows");
	end

	initial begin
		int fd;
		int code;
		int slot;
		int fnum;
		int blk;
		int mul;
		int step;
		int latency;
		string line;
		logic [7:0] op;
		logic [31:0] word;
		logic [31:0] rdata;
		logic err;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		reset = 1'b1;
		lines_counted = 1'b0;
		n_lines = 0;
		fd = $fopen("verif/phase_stim.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open verif/phase_stim.txt");
		end
		while ($fgets(line, fd) != 0) begin
			n_lines++;
		end
		$fclose(fd);
		lines_counted = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		check_reset_stream();
		fd = $fopen("verif/phase_stim.txt", "r");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2) begin
				continue;
			end
			op = line.getc(0);
			if (op == "#") begin
				continue;
			end
			code = $sscanf(line.substr(1, line.len() - 1), "%d %h %d %d %h",
				slot, fnum, blk, mul, step);
			if (code != 5) begin
				abort_run($sformatf("malformed stimulus line: %s", line));
			end
			word = cfg_word(fnum, blk, mul);
			case (op)
				"W": begin
					apb_transfer(1'b1, slot, word, rdata, err, latency);
					check_equal("pslverr", 32'(err), 32'd0);
				end
				"R": begin
					apb_transfer(1'b0, slot, 32'd0, rdata, err, latency);
					check_equal("pslverr", 32'(err), 32'd0);
					check_equal("prdata", rdata, word);
				end
				"E": begin
					// A bad slot must end on its first access cycle.
					apb_transfer(1'b1, slot, word, rdata, err, latency);
					check_equal("pslverr", 32'(err), 32'd1);
					check_equal("pready latency", 32'(latency), 32'd0);
				end
				"C": begin
					check_step(slot_idx_t'(slot), 32'(step));
				end
				default: begin
					abort_run($sformatf("unknown operation in stimulus line: %s", line));
				end
			endcase
		end
		$fclose(fd);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: verif/phase_stim.txt
# op slot fnum(hex) block mult step(hex)
# W write, R read back, E expect pslverr, C check the phase step over two frames
W 0 100 4 1 00800
W 1 2a5 3 2 01528
W 2 155 0 0 00055
W 5 7ff 7 15 dfc40
W 23 3e8 7 0 07d00
W 10 001 0 3 00000
W 7 400 2 7 03800
R 0 100 4 1 00800
R 1 2a5 3 2 01528
R 2 155 0 0 00055
R 5 7ff 7 15 dfc40
R 23 3e8 7 0 07d00
E 24 3ff 5 9 00000
E 31 123 1 1 00000
R 0 100 4 1 00800
C 0 100 4 1 00800
C 1 2a5 3 2 01528
C 2 155 0 0 00055
C 5 7ff 7 15 dfc40
C 23 3e8 7 0 07d00
C 10 001 0 3 00000
C 7 400 2 7 03800
C 3 000 0 0 00000
W 1 200 1 4 00800
C 1 200 1 4 00800
C 0 100 4 1 00800
C 2 155 0 0 00055
C 5 7ff 7 15 dfc40
R 1 200 1 4 00800

// File: all.f
common/opn_pkg.sv
source/slot_ring.sv
source/slot_timer.sv
regs/apb_slot_regs.sv
phase/phase_step.sv
phase/phase_gen.sv
source/slot_out.sv
source/opn_phase_top.sv
verif/opn_phase_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the phase generator testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module opn_phase_tb -f all.f -Mdir obj_dir -o opn_phase_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/opn_phase_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
